// ==== include/boot_rom_image.svh ====
// Small boot stub that sets up the stack in local RAM and spins
localparam logic [31:0] BOOT_IMAGE [soc_pkg::ROM_WORDS] = '{
	32'h20110137,
	32'h200002b7,
	32'h50000337,
	32'h09030313,
	32'h00100393,
	32'h00732223,
	32'h0002a503,
	32'h00a2a023,
	32'h00428293,
	32'hfe0298e3,
	32'h00000013,
	32'h00000013,
	32'h0000006f,
	32'hdeadbeef,
	32'h0badc0de,
	32'h5a5aa5a5
};

// ==== hw/soc_pkg.sv ====
package soc_pkg;

	// ========================================================================
	// Near bus, between the masters, the arbiter and the slaves
	// ========================================================================

	typedef struct packed {
		logic        write;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// Read data is only meaningful in the cycle where ready is high
	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
	} bus_rsp_t;

	// ========================================================================
	// Far bus, behind the peripheral bridge
	// ========================================================================

	// Offset is the near address with the region nibble stripped
	typedef struct packed {
		logic        write;
		logic [27:0] offset;
		logic [31:0] wdata;
	} far_req_t;

	// Near regions, address bits 31:28
	localparam logic [3:0] REGION_ROM    = 4'h0;
	localparam logic [3:0] REGION_RAM    = 4'h2;
	localparam logic [3:0] REGION_BRIDGE = 4'h5;

	// Far regions, offset bits 27:24
	localparam logic [3:0] FAR_TIMER  = 4'h5;
	localparam logic [3:0] FAR_SYSREG = 4'h9;

	// System register word offsets, offset bits 3:2
	localparam logic [1:0] SYSREG_ID      = 2'd0;
	localparam logic [1:0] SYSREG_LEDS    = 2'd1;
	localparam logic [1:0] SYSREG_SCRATCH = 2'd2;

	// Timer word offsets, offset bits 3:2
	localparam logic [1:0] TIMER_COUNT   = 2'd0;
	localparam logic [1:0] TIMER_COMPARE = 2'd1;
	localparam logic [1:0] TIMER_STATUS  = 2'd2;

	// Boot image depth in words
	localparam int ROM_WORDS = 16;

endpackage

// ==== hw/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom (
	input  logic              i_clock,
	input  logic              i_rst,
	input  logic              i_request,
	input  logic [3:0]        i_address,
	output soc_pkg::bus_rsp_t o_rsp
);

	`include "boot_rom_image.svh"

	logic [31:0] rdata;
	logic        ready;

	// Word lookup
	always_ff @(posedge i_clock) begin
		rdata <= BOOT_IMAGE[i_address];
	end

	// Ready pulses once even though the bus keeps the request up
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready <= 1'b0;
		end else begin
			ready <= i_request && !ready;
		end
	end

	assign o_rsp = '{rdata: rdata, ready: ready};

endmodule

// ==== hw/local_ram.sv ====
`timescale 1ns/1ps

module local_ram #(
	parameter int RAM_WORDS_LOG2 = 10
) (
	input  logic              i_clock,
	input  logic              i_rst,
	input  logic              i_request,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp
);

	logic [31:0]               mem [2**RAM_WORDS_LOG2];
	logic [RAM_WORDS_LOG2-1:0] index;
	logic [31:0]               rdata;
	logic                      ready;

	// Byte address to word index
	assign index = i_req.address[RAM_WORDS_LOG2+1:2];

	// Single port, access happens on the first edge of the request
	always_ff @(posedge i_clock) begin
		if (i_request && !ready) begin
			if (i_req.write) begin
				mem[index] <= i_req.wdata;
			end
			rdata <= mem[index];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready <= 1'b0;
		end else begin
			ready <= i_request && !ready;
		end
	end

	assign o_rsp = '{rdata: rdata, ready: ready};

endmodule

// ==== hw/system_bus.sv ====
`timescale 1ns/1ps

module system_bus (
	input  logic              i_clock,
	input  logic              i_rst,

	// Instruction port
	input  logic              i_ibus_request,
	input  logic [31:0]       i_ibus_address,
	output soc_pkg::bus_rsp_t o_ibus_rsp,

	// Data port
	input  logic              i_dbus_request,
	input  soc_pkg::bus_req_t i_dbus_req,
	output soc_pkg::bus_rsp_t o_dbus_rsp,

	// DMA port
	input  logic              i_dma_request,
	input  soc_pkg::bus_req_t i_dma_req,
	output soc_pkg::bus_rsp_t o_dma_rsp,

	// Slaves
	output logic              o_rom_request,
	output logic              o_ram_request,
	output logic              o_bridge_request,
	output soc_pkg::bus_req_t o_slave_req,
	input  soc_pkg::bus_rsp_t i_rom_rsp,
	input  soc_pkg::bus_rsp_t i_ram_rsp,
	input  soc_pkg::bus_rsp_t i_bridge_rsp
);

	localparam logic [1:0] PORT_IBUS = 2'd0;
	localparam logic [1:0] PORT_DBUS = 2'd1;
	localparam logic [1:0] PORT_DMA  = 2'd2;

	logic              busy;
	logic [1:0]        owner;
	soc_pkg::bus_req_t cmd;
	logic [3:0]        region;
	logic              rom_select;
	logic              ram_select;
	logic              bridge_select;
	logic              unmapped_ready;
	soc_pkg::bus_rsp_t sel_rsp;

	// ========================================================================
	// Arbiter, data first, then DMA, then instruction
	// ========================================================================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			busy  <= 1'b0;
			owner <= PORT_IBUS;
		end else if (!busy) begin
			if (i_dbus_request) begin
				busy  <= 1'b1;
				owner <= PORT_DBUS;
			end else if (i_dma_request) begin
				busy  <= 1'b1;
				owner <= PORT_DMA;
			end else if (i_ibus_request) begin
				busy  <= 1'b1;
				owner <= PORT_IBUS;
			end
		end else if (sel_rsp.ready) begin
			// Free the bus on the edge after the slave answered
			busy <= 1'b0;
		end
	end

	// Command register follows the same priority
	always_ff @(posedge i_clock) begin
		if (!busy) begin
			if (i_dbus_request) begin
				cmd <= i_dbus_req;
			end else if (i_dma_request) begin
				cmd <= i_dma_req;
			end else begin
				cmd <= '{write: 1'b0, address: i_ibus_address, wdata: 32'h0};
			end
		end
	end

	// ========================================================================
	// Region decode and response mux
	// ========================================================================

	assign region        = cmd.address[31:28];
	assign rom_select    = region == soc_pkg::REGION_ROM;
	assign ram_select    = region == soc_pkg::REGION_RAM;
	assign bridge_select = region == soc_pkg::REGION_BRIDGE;

	assign o_rom_request    = busy && rom_select;
	assign o_ram_request    = busy && ram_select;
	assign o_bridge_request = busy && bridge_select;
	assign o_slave_req      = cmd;

	// Unmapped regions answer zero after one cycle, like a fast slave
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= busy && !(rom_select || ram_select || bridge_select)
				&& !unmapped_ready;
		end
	end

	always_comb begin
		if (rom_select) begin
			sel_rsp = i_rom_rsp;
		end else if (ram_select) begin
			sel_rsp = i_ram_rsp;
		end else if (bridge_select) begin
			sel_rsp = i_bridge_rsp;
		end else begin
			sel_rsp = '{rdata: 32'h0, ready: unmapped_ready};
		end
	end

	// Only the owner sees the ready
	assign o_ibus_rsp = '{rdata: sel_rsp.rdata,
		ready: busy && sel_rsp.ready && owner == PORT_IBUS};
	assign o_dbus_rsp = '{rdata: sel_rsp.rdata,
		ready: busy && sel_rsp.ready && owner == PORT_DBUS};
	assign o_dma_rsp  = '{rdata: sel_rsp.rdata,
		ready: busy && sel_rsp.ready && owner == PORT_DMA};

endmodule

// ==== hw/periph_bridge.sv ====
`timescale 1ns/1ps

module periph_bridge (
	input  logic              i_clock,
	input  logic              i_rst,

	// Near side
	input  logic              i_request,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp,

	// Far side
	output logic              o_sysreg_request,
	output logic              o_timer_request,
	output soc_pkg::far_req_t o_far_req,
	input  soc_pkg::bus_rsp_t i_sysreg_rsp,
	input  soc_pkg::bus_rsp_t i_timer_rsp
);

	logic              active;
	logic              far_request;
	soc_pkg::far_req_t far_cmd;
	logic              sysreg_select;
	logic              timer_select;
	logic              far_unmapped_ready;
	soc_pkg::bus_rsp_t far_rsp;
	logic [31:0]       rsp_rdata;
	logic              rsp_ready;

	// ========================================================================
	// Near to far, one register stage
	// ========================================================================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			active      <= 1'b0;
			far_request <= 1'b0;
		end else if (!active) begin
			if (i_request) begin
				active      <= 1'b1;
				far_request <= 1'b1;
			end
		end else begin
			if (far_request && far_rsp.ready) begin
				far_request <= 1'b0;
			end
			// Stay busy until the near ready has gone out, the bus still
			// holds the request in that cycle
			if (rsp_ready) begin
				active <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!active && i_request) begin
			far_cmd <= '{write: i_req.write, offset: i_req.address[27:0], wdata: i_req.wdata};
		end
	end

	// Far decode
	assign sysreg_select = far_cmd.offset[27:24] == soc_pkg::FAR_SYSREG;
	assign timer_select  = far_cmd.offset[27:24] == soc_pkg::FAR_TIMER;

	assign o_sysreg_request = far_request && sysreg_select;
	assign o_timer_request  = far_request && timer_select;
	assign o_far_req        = far_cmd;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			far_unmapped_ready <= 1'b0;
		end else begin
			far_unmapped_ready <= far_request && !(sysreg_select || timer_select)
				&& !far_unmapped_ready;
		end
	end

	always_comb begin
		if (sysreg_select) begin
			far_rsp = i_sysreg_rsp;
		end else if (timer_select) begin
			far_rsp = i_timer_rsp;
		end else begin
			far_rsp = '{rdata: 32'h0, ready: far_unmapped_ready};
		end
	end

	// ========================================================================
	// Far to near, one register stage
	// ========================================================================

	always_ff @(posedge i_clock) begin
		rsp_rdata <= far_rsp.rdata;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			rsp_ready <= 1'b0;
		end else begin
			rsp_ready <= far_request && far_rsp.ready;
		end
	end

	assign o_rsp = '{rdata: rsp_rdata, ready: rsp_ready};

endmodule

// ==== hw/system_registers.sv ====
`timescale 1ns/1ps

module system_registers #(
	parameter logic [31:0] DEVICE_ID = 32'd6
) (
	input  logic              i_clock,
	input  logic              i_rst,
	input  logic              i_request,
	input  soc_pkg::far_req_t i_far_req,
	output soc_pkg::bus_rsp_t o_rsp,
	output logic [7:0]        o_leds
);

	logic [1:0]  reg_index;
	logic [7:0]  leds;
	logic [31:0] scratch;
	logic [31:0] rdata;
	logic        ready;

	assign reg_index = i_far_req.offset[3:2];

	// Register writes, once per access
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			leds    <= 8'h00;
			scratch <= 32'h0;
		end else if (i_request && !ready && i_far_req.write) begin
			case (reg_index)
				soc_pkg::SYSREG_LEDS:    leds    <= i_far_req.wdata[7:0];
				soc_pkg::SYSREG_SCRATCH: scratch <= i_far_req.wdata;
				default: ;
			endcase
		end
	end

	// Read mux, ID is fixed
	always_ff @(posedge i_clock) begin
		case (reg_index)
			soc_pkg::SYSREG_ID:      rdata <= DEVICE_ID;
			soc_pkg::SYSREG_LEDS:    rdata <= {24'h0, leds};
			soc_pkg::SYSREG_SCRATCH: rdata <= scratch;
			default:                 rdata <= 32'h0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready <= 1'b0;
		end else begin
			ready <= i_request && !ready;
		end
	end

	assign o_rsp  = '{rdata: rdata, ready: ready};
	assign o_leds = leds;

endmodule

// ==== hw/interval_timer.sv ====
`timescale 1ns/1ps

module interval_timer (
	input  logic              i_clock,
	input  logic              i_rst,
	input  logic              i_request,
	input  soc_pkg::far_req_t i_far_req,
	output soc_pkg::bus_rsp_t o_rsp,
	output logic              o_timer_irq
);

	logic [1:0]  reg_index;
	logic        write_strobe;
	logic [31:0] counter;
	logic [31:0] compare;
	logic        pending;
	logic [31:0] rdata;
	logic        ready;

	assign reg_index    = i_far_req.offset[3:2];
	assign write_strobe = i_request && !ready && i_far_req.write;

	// ========================================================================
	// Counter, compare and pending flag
	// ========================================================================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			counter <= 32'h0;
			compare <= 32'h0;
			pending <= 1'b0;
		end else begin
			counter <= counter + 32'd1;
			// A zero compare keeps the timer disarmed
			if (compare != 32'h0 && counter == compare) begin
				pending <= 1'b1;
			end
			// Bus writes take priority over the match
			if (write_strobe && reg_index == soc_pkg::TIMER_COMPARE) begin
				compare <= i_far_req.wdata;
				counter <= 32'h0;
				pending <= 1'b0;
			end else if (write_strobe && reg_index == soc_pkg::TIMER_STATUS
				&& i_far_req.wdata[0]) begin
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		case (reg_index)
			soc_pkg::TIMER_COUNT:   rdata <= counter;
			soc_pkg::TIMER_COMPARE: rdata <= compare;
			soc_pkg::TIMER_STATUS:  rdata <= {31'h0, pending};
			default:                rdata <= 32'h0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready <= 1'b0;
		end else begin
			ready <= i_request && !ready;
		end
	end

	assign o_rsp       = '{rdata: rdata, ready: ready};
	assign o_timer_irq = pending;

endmodule

// ==== hw/soc_fabric.sv ====
`timescale 1ns/1ps

module soc_fabric #(
	parameter logic [31:0] DEVICE_ID      = 32'd6,
	parameter int          RAM_WORDS_LOG2 = 10
) (
	input  logic              i_clock,
	input  logic              i_rst,

	input  logic              i_ibus_request,
	input  logic [31:0]       i_ibus_address,
	output soc_pkg::bus_rsp_t o_ibus_rsp,

	input  logic              i_dbus_request,
	input  soc_pkg::bus_req_t i_dbus_req,
	output soc_pkg::bus_rsp_t o_dbus_rsp,

	input  logic              i_dma_request,
	input  soc_pkg::bus_req_t i_dma_req,
	output soc_pkg::bus_rsp_t o_dma_rsp,

	output logic [7:0]        o_leds,
	output logic              o_timer_irq
);

	logic              rom_request;
	logic              ram_request;
	logic              bridge_request;
	soc_pkg::bus_req_t slave_req;
	soc_pkg::bus_rsp_t rom_rsp;
	soc_pkg::bus_rsp_t ram_rsp;
	soc_pkg::bus_rsp_t bridge_rsp;

	logic              sysreg_request;
	logic              timer_request;
	soc_pkg::far_req_t far_req;
	soc_pkg::bus_rsp_t sysreg_rsp;
	soc_pkg::bus_rsp_t timer_rsp;

	// ========================================================================
	// Near bus
	// ========================================================================

	system_bus bus (
		.i_clock          (i_clock),
		.i_rst            (i_rst),
		.i_ibus_request   (i_ibus_request),
		.i_ibus_address   (i_ibus_address),
		.o_ibus_rsp       (o_ibus_rsp),
		.i_dbus_request   (i_dbus_request),
		.i_dbus_req       (i_dbus_req),
		.o_dbus_rsp       (o_dbus_rsp),
		.i_dma_request    (i_dma_request),
		.i_dma_req        (i_dma_req),
		.o_dma_rsp        (o_dma_rsp),
		.o_rom_request    (rom_request),
		.o_ram_request    (ram_request),
		.o_bridge_request (bridge_request),
		.o_slave_req      (slave_req),
		.i_rom_rsp        (rom_rsp),
		.i_ram_rsp        (ram_rsp),
		.i_bridge_rsp     (bridge_rsp)
	);

	// Boot ROM ($00000000), word index from the byte address
	boot_rom rom (
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_request (rom_request),
		.i_address (slave_req.address[5:2]),
		.o_rsp     (rom_rsp)
	);

	// Local RAM ($20000000)
	local_ram #(
		.RAM_WORDS_LOG2 (RAM_WORDS_LOG2)
	) ram (
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_request (ram_request),
		.i_req     (slave_req),
		.o_rsp     (ram_rsp)
	);

	// ========================================================================
	// Peripheral bridge ($50000000) and far devices
	// ========================================================================

	periph_bridge bridge (
		.i_clock          (i_clock),
		.i_rst            (i_rst),
		.i_request        (bridge_request),
		.i_req            (slave_req),
		.o_rsp            (bridge_rsp),
		.o_sysreg_request (sysreg_request),
		.o_timer_request  (timer_request),
		.o_far_req        (far_req),
		.i_sysreg_rsp     (sysreg_rsp),
		.i_timer_rsp      (timer_rsp)
	);

	system_registers #(
		.DEVICE_ID (DEVICE_ID)
	) sysreg (
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_request (sysreg_request),
		.i_far_req (far_req),
		.o_rsp     (sysreg_rsp),
		.o_leds    (o_leds)
	);

	interval_timer timer (
		.i_clock     (i_clock),
		.i_rst       (i_rst),
		.i_request   (timer_request),
		.i_far_req   (far_req),
		.o_rsp       (timer_rsp),
		.o_timer_irq (o_timer_irq)
	);

endmodule

// ==== verif/soc_fabric_assertions.sv ====
`timescale 1ns/1ps

module soc_fabric_assertions (
	input logic              i_clock,
	input logic              i_rst,
	input logic              i_ibus_request,
	input logic [31:0]       i_ibus_address,
	input soc_pkg::bus_rsp_t i_ibus_rsp,
	input logic              i_dbus_request,
	input soc_pkg::bus_req_t i_dbus_req,
	input soc_pkg::bus_rsp_t i_dbus_rsp,
	input logic              i_dma_request,
	input soc_pkg::bus_req_t i_dma_req,
	input soc_pkg::bus_rsp_t i_dma_rsp,
	input logic [7:0]        i_leds,
	input logic              i_timer_irq
);

	logic [2:0]  readies;
	logic [2:0]  requests;
	int unsigned failures = 0;

	assign readies  = {i_ibus_rsp.ready, i_dbus_rsp.ready, i_dma_rsp.ready};
	assign requests = {i_ibus_request, i_dbus_request, i_dma_request};

	// ========================================================================
	// Handshake on the three master ports
	// ========================================================================

	// Ready never stays up for two cycles on the same port
	ready_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
		(readies & $past(readies)) == 3'b000)
		else begin
			failures++;
			$error("Ready stayed high for more than one cycle");
		end

	ready_has_request: assert property (@(posedge i_clock) disable iff (i_rst)
		(readies & ~requests) == 3'b000)
		else begin
			failures++;
			$error("Ready seen on a port without a pending request");
		end

	// Master holds request and command until its ready
	ibus_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		i_ibus_request && !i_ibus_rsp.ready |=> i_ibus_request && $stable(i_ibus_address))
		else begin
			failures++;
			$error("Instruction port request changed before ready");
		end

	dbus_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		i_dbus_request && !i_dbus_rsp.ready |=> i_dbus_request && $stable(i_dbus_req))
		else begin
			failures++;
			$error("Data port request changed before ready");
		end

	dma_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		i_dma_request && !i_dma_rsp.ready |=> i_dma_request && $stable(i_dma_req))
		else begin
			failures++;
			$error("DMA port request changed before ready");
		end

	// ========================================================================
	// Reset state
	// ========================================================================

	reset_quiet: assert property (@(posedge i_clock)
		i_rst |=> !i_timer_irq && readies == 3'b000 && i_leds == 8'h00)
		else begin
			failures++;
			$error("Outputs not quiet in the cycle after reset");
		end

endmodule

// ==== verif/tb_soc_fabric.sv ====
`timescale 1ns/1ps

module tb_soc_fabric;

	localparam int PORT_IBUS      = 0;
	localparam int PORT_DBUS      = 1;
	localparam int PORT_DMA       = 2;
	localparam int ACCESS_TIMEOUT = 200;
	localparam int IRQ_TIMEOUT    = 100;
	localparam logic [31:0] EXPECTED_ID  = 32'd6;
	localparam logic [31:0] RAM_BASE     = {soc_pkg::REGION_RAM, 28'h0};
	localparam logic [31:0] UNMAPPED     = 32'h7000_0000;

	`include "boot_rom_image.svh"

	logic              clock = 1'b0;
	logic              rst;
	logic              ibus_request;
	logic [31:0]       ibus_address;
	soc_pkg::bus_rsp_t ibus_rsp;
	logic              dbus_request;
	soc_pkg::bus_req_t dbus_req;
	soc_pkg::bus_rsp_t dbus_rsp;
	logic              dma_request;
	soc_pkg::bus_req_t dma_req;
	soc_pkg::bus_rsp_t dma_rsp;
	logic [7:0]        leds;
	logic              timer_irq;

	logic [15:0]       lfsr_state;
	logic [31:0]       ram_model [logic [31:0]];

	always #4 clock = ~clock;

	soc_fabric #(
		.DEVICE_ID      (EXPECTED_ID),
		.RAM_WORDS_LOG2 (10)
	) UUT (
		.i_clock        (clock),
		.i_rst          (rst),
		.i_ibus_request (ibus_request),
		.i_ibus_address (ibus_address),
		.o_ibus_rsp     (ibus_rsp),
		.i_dbus_request (dbus_request),
		.i_dbus_req     (dbus_req),
		.o_dbus_rsp     (dbus_rsp),
		.i_dma_request  (dma_request),
		.i_dma_req      (dma_req),
		.o_dma_rsp      (dma_rsp),
		.o_leds         (leds),
		.o_timer_irq    (timer_irq)
	);

	bind soc_fabric soc_fabric_assertions checks (
		.i_clock        (i_clock),
		.i_rst          (i_rst),
		.i_ibus_request (i_ibus_request),
		.i_ibus_address (i_ibus_address),
		.i_ibus_rsp     (o_ibus_rsp),
		.i_dbus_request (i_dbus_request),
		.i_dbus_req     (i_dbus_req),
		.i_dbus_rsp     (o_dbus_rsp),
		.i_dma_request  (i_dma_request),
		.i_dma_req      (i_dma_req),
		.i_dma_rsp      (o_dma_rsp),
		.i_leds         (o_leds),
		.i_timer_irq    (o_timer_irq)
	);

	// Stop at the first failed bus assertion
	always @(UUT.checks.failures) begin
		if (UUT.checks.failures != 0) begin
			$display("A bus handshake assertion failed");
			$display("Some tests failed");
			$fatal(1, "Stopped at the first assertion failure");
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	task automatic next_random(output logic [31:0] value);
		value = 32'h0;
		for (int i = 0; i < 32; i++) begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Far bus address of a register word behind the bridge
	function automatic logic [31:0] reg_address(input logic [3:0] far_region,
		input logic [1:0] word);
		return {soc_pkg::REGION_BRIDGE, far_region, 20'h0, word, 2'b00};
	endfunction

	function automatic soc_pkg::bus_rsp_t port_rsp(input int port);
		case (port)
			PORT_IBUS: return ibus_rsp;
			PORT_DBUS: return dbus_rsp;
			default:   return dma_rsp;
		endcase
	endfunction

	task automatic drive_port(input int port, input logic request,
		input soc_pkg::bus_req_t req);
		case (port)
			PORT_IBUS: begin
				ibus_request = request;
				ibus_address = req.address;
			end
			PORT_DBUS: begin
				dbus_request = request;
				dbus_req     = req;
			end
			default: begin
				dma_request = request;
				dma_req     = req;
			end
		endcase
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first error");
		end
	endtask

	// One access held until its ready, which is sampled on the falling edge
	task automatic bus_access(input int port, input logic write, input logic [31:0] address,
		input logic [31:0] wdata, output logic [31:0] rdata);
		soc_pkg::bus_rsp_t rsp;
		int                cycles;
		cycles = 0;
		@(posedge clock);
		#1;
		drive_port(port, 1'b1, '{write: write, address: address, wdata: wdata});
		do begin
			@(negedge clock);
			rsp = port_rsp(port);
			cycles++;
		end while (!rsp.ready && cycles < ACCESS_TIMEOUT);
		if (!rsp.ready) begin
			$display("Port %0d got no ready within %0d cycles at address %h",
				port, ACCESS_TIMEOUT, address);
			$display("Some tests failed");
			$fatal(1, "Bus access timed out");
		end
		rdata = rsp.rdata;
		@(posedge clock);
		#1;
		drive_port(port, 1'b0, '0);
	endtask

	task automatic write_word(input int port, input logic [31:0] address,
		input logic [31:0] wdata);
		logic [31:0] unused;
		bus_access(port, 1'b1, address, wdata, unused);
		if (address[31:28] == soc_pkg::REGION_RAM) begin
			ram_model[address] = wdata;
		end
	endtask

	task automatic read_check(input int port, input logic [31:0] address,
		input logic [31:0] expected, input string name);
		logic [31:0] rdata;
		bus_access(port, 1'b0, address, 32'h0, rdata);
		check_value(name, expected, rdata);
	endtask

	task automatic wait_for_irq();
		int cycles;
		cycles = 0;
		while (!timer_irq && cycles < IRQ_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!timer_irq) begin
			$display("Timer interrupt did not rise within %0d cycles", IRQ_TIMEOUT);
			$display("Some tests failed");
			$fatal(1, "Timer interrupt timed out");
		end
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		logic [31:0] data;
		logic [31:0] dma_words [8];
		rst          = 1'b1;
		ibus_request = 1'b0;
		ibus_address = 32'h0;
		dbus_request = 1'b0;
		dbus_req     = '0;
		dma_request  = 1'b0;
		dma_req      = '0;
		lfsr_state   = 16'd51841;
		repeat (16) @(posedge clock);
		#1;
		rst = 1'b0;

		// Boot image over the instruction port
		for (int i = 0; i < soc_pkg::ROM_WORDS; i++) begin
			read_check(PORT_IBUS, i * 4, BOOT_IMAGE[i], $sformatf("rom word %0d", i));
		end

		// RAM written on one port and read on the other
		for (int i = 0; i < 8; i++) begin
			next_random(data);
			write_word(PORT_DBUS, RAM_BASE + i * 4, data);
			read_check(PORT_DMA, RAM_BASE + i * 4, data, $sformatf("ram dbus to dma %0d", i));
		end
		for (int i = 0; i < 8; i++) begin
			next_random(data);
			write_word(PORT_DMA, RAM_BASE + 32'h100 + i * 4, data);
			read_check(PORT_DBUS, RAM_BASE + 32'h100 + i * 4, data,
				$sformatf("ram dma to dbus %0d", i));
		end

		// All three ports at once
		for (int i = 0; i < 8; i++) begin
			next_random(dma_words[i]);
		end
		fork
			begin
				for (int i = 0; i < soc_pkg::ROM_WORDS; i++) begin
					read_check(PORT_IBUS, i * 4, BOOT_IMAGE[i],
						$sformatf("contention rom %0d", i));
				end
			end
			begin
				for (int i = 0; i < 8; i++) begin
					read_check(PORT_DBUS, RAM_BASE + i * 4, ram_model[RAM_BASE + i * 4],
						$sformatf("contention dbus ram %0d", i));
				end
			end
			begin
				for (int i = 0; i < 8; i++) begin
					write_word(PORT_DMA, RAM_BASE + 32'h200 + i * 4, dma_words[i]);
					read_check(PORT_DMA, RAM_BASE + 32'h200 + i * 4, dma_words[i],
						$sformatf("contention dma ram %0d", i));
				end
			end
		join

		// System registers
		read_check(PORT_DBUS, reg_address(soc_pkg::FAR_SYSREG, soc_pkg::SYSREG_ID),
			EXPECTED_ID, "sysreg id");
		next_random(data);
		write_word(PORT_DBUS, reg_address(soc_pkg::FAR_SYSREG, soc_pkg::SYSREG_LEDS), data);
		check_value("leds output", {24'h0, data[7:0]}, {24'h0, leds});
		read_check(PORT_DBUS, reg_address(soc_pkg::FAR_SYSREG, soc_pkg::SYSREG_LEDS),
			{24'h0, data[7:0]}, "leds readback");
		next_random(data);
		write_word(PORT_DMA, reg_address(soc_pkg::FAR_SYSREG, soc_pkg::SYSREG_SCRATCH), data);
		read_check(PORT_DBUS, reg_address(soc_pkg::FAR_SYSREG, soc_pkg::SYSREG_SCRATCH),
			data, "scratch readback");

		// Timer interrupt and its clear through STATUS
		write_word(PORT_DBUS, reg_address(soc_pkg::FAR_TIMER, soc_pkg::TIMER_COMPARE), 32'd20);
		wait_for_irq();
		write_word(PORT_DBUS, reg_address(soc_pkg::FAR_TIMER, soc_pkg::TIMER_STATUS), 32'd1);
		check_value("timer irq after clear", 32'h0, {31'h0, timer_irq});
		read_check(PORT_DBUS, reg_address(soc_pkg::FAR_TIMER, soc_pkg::TIMER_STATUS),
			32'h0, "timer status after clear");

		// Holes in the map read as zero
		read_check(PORT_DBUS, UNMAPPED, 32'h0, "unmapped region 7");
		read_check(PORT_DMA, reg_address(4'h3, 2'd0), 32'h0, "unmapped far region 3");

		if (UUT.checks.failures == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "Bus assertions failed during the run");
		end
	end

endmodule

// ==== build.f ====
+incdir+include
hw/soc_pkg.sv
hw/boot_rom.sv
hw/local_ram.sv
hw/system_bus.sv
hw/periph_bridge.sv
hw/system_registers.sv
hw/interval_timer.sv
hw/soc_fabric.sv
verif/soc_fabric_assertions.sv
verif/tb_soc_fabric.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_soc_fabric -Mdir obj_dir -o sim_tb -f build.f > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
grep -qx "All tests passed" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
